//--- design/motion_pkg.sv
// Motion package with the DDA, move duration and tick divisor types
package motion_pkg;

  // DDA arithmetic
  // Increment, acceleration and accumulator all share this width
  localparam int dda_bits = 64;

  // Signed so that negative accelerations decelerate a move
  typedef logic signed [dda_bits-1:0] dda_word_t;

  // Move length
  localparam int move_duration_bits = 32;

  typedef logic [move_duration_bits-1:0] duration_t;  // Counted in DDA ticks

  // DDA tick divider
  typedef logic [7:0] divisor_t;  // System clocks per DDA tick

  // Value after reset, until the host writes a new divisor
  localparam divisor_t default_clock_divisor = 8'd32;

endpackage

//--- design/host_cmd_pkg.sv
// Host command package with the word layout and the command header codes
package host_cmd_pkg;

  // One host transfer
  localparam int word_bits = 64;

  typedef logic [word_bits-1:0] host_word_t;

  // Command header sits in the top byte of the first word
  localparam int header_msb = 63;

  typedef logic [7:0] header_t;

  // Multi-word move, 2 + 2 * num_motors words in total
  localparam header_t cmd_coordinated_step = 8'h01;

  // Single-word control commands
  localparam header_t cmd_motor_enable = 8'h0a;
  localparam header_t cmd_motor_brake  = 8'h0b;
  localparam header_t cmd_clk_divisor  = 8'h20;

  // Reply carries the build widths
  localparam header_t cmd_channel_info = 8'hfd;

endpackage

//--- design/host_command_decoder.sv
// Host command decoder that applies control commands and fills the move buffer
`timescale 1ns/1ns

module host_command_decoder
  import motion_pkg::*;
  import host_cmd_pkg::*;
#(
  parameter int num_motors = 2,
  parameter int buffer_size = 2,
  localparam int idx_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1
) (
  input  logic                             CLK,
  input  logic                             resetn,
  input  host_word_t                       word_data_received,
  input  logic                             word_received,
  input  logic [idx_bits-1:0]              moveind,
  output host_word_t                       word_send_data,
  output logic [num_motors-1:0]            enable,
  output logic [num_motors-1:0]            brake,
  output divisor_t                         clock_divisor,
  output logic [buffer_size-1:0]           stepready,
  output logic [num_motors-1:0]            active_dir,
  output duration_t                        active_duration,
  output dda_word_t [num_motors-1:0]       active_increment,
  output dda_word_t [num_motors-1:0]       active_accel
);

  localparam int msg_words = 2 + 2 * num_motors;  // Words in one coordinated step
  localparam int count_bits = $clog2(msg_words);

  logic                  word_received_q;
  logic                  word_rise;
  logic                  in_move;  // A move message is being collected
  header_t               header;
  header_t               message_header;
  logic [count_bits-1:0] word_count;  // Index of the current word in the message
  logic [idx_bits-1:0]   writemoveind;

  // Move buffer, one entry per slot
  logic [num_motors-1:0]       dir_mem       [buffer_size];
  duration_t                   duration_mem  [buffer_size];
  dda_word_t [num_motors-1:0]  increment_mem [buffer_size];
  dda_word_t [num_motors-1:0]  accel_mem     [buffer_size];

  assign word_rise = word_received && !word_received_q;
  assign header    = word_data_received[header_msb -: 8];
  assign in_move   = (message_header == cmd_coordinated_step);

  // Header tracking and control registers
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      word_send_data  <= '0;
      enable          <= '0;
      brake           <= '0;
      clock_divisor   <= default_clock_divisor;
      stepready       <= '0;
      writemoveind    <= '0;
      message_header  <= '0;
      word_count      <= '0;
      for (int s = 0; s < buffer_size; s++)
        dir_mem[s] <= '0;
    end else begin
      word_received_q <= word_received;
      if (word_rise) begin
        word_send_data <= '0;  // Reply is zero unless loaded below
        if (!in_move) begin
          message_header <= header;
          word_count     <= count_bits'(1);
          case (header)
            cmd_coordinated_step:
              dir_mem[writemoveind] <= word_data_received[num_motors-1:0];
            cmd_motor_enable:
              enable <= word_data_received[num_motors-1:0];
            cmd_motor_brake:
              brake <= word_data_received[num_motors-1:0];
            cmd_clk_divisor:
              clock_divisor <= word_data_received[7:0];
            cmd_channel_info: begin
              word_send_data[7:0]   <= 8'(num_motors);
              word_send_data[15:8]  <= 8'(move_duration_bits);
              word_send_data[23:16] <= 8'(dda_bits);
              word_send_data[31:24] <= 8'(buffer_size);
            end
            default: ;  // Unknown header, reply stays zero
          endcase
        end else begin
          word_count <= word_count + 1'b1;
          // Last acceleration word completes the move
          if (word_count == count_bits'(msg_words - 1)) begin
            stepready[writemoveind] <= ~stepready[writemoveind];  // Hand slot over
            writemoveind            <= writemoveind + 1'b1;
            message_header          <= '0;
          end
        end
      end
    end
  end

  // Move payload, written into the slot being filled
  always_ff @(posedge CLK) begin
    if (word_rise && in_move) begin
      if (word_count == count_bits'(1))
        duration_mem[writemoveind] <= word_data_received[move_duration_bits-1:0];
      for (int a = 0; a < num_motors; a++) begin
        if (word_count == count_bits'(2 + 2 * a))
          increment_mem[writemoveind][a] <= word_data_received;
        if (word_count == count_bits'(3 + 2 * a))
          accel_mem[writemoveind][a] <= word_data_received;
      end
    end
  end

  // Slot selected by the sequencer
  assign active_dir       = dir_mem[moveind];
  assign active_duration  = duration_mem[moveind];
  assign active_increment = increment_mem[moveind];
  assign active_accel     = accel_mem[moveind];

endmodule

//--- design/move_sequencer.sv
// Move sequencer that paces DDA ticks and executes buffered moves in order
`timescale 1ns/1ns

module move_sequencer
  import motion_pkg::*;
#(
  parameter int buffer_size = 2,
  localparam int idx_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  divisor_t               clock_divisor,
  input  logic [buffer_size-1:0] stepready,
  input  duration_t              active_duration,
  output logic [idx_bits-1:0]    moveind,
  output logic                   dda_tick,
  output logic                   loading_move,
  output logic                   executing_move,
  output logic                   move_done,
  output logic                   buffer_dtr
);

  divisor_t               tick_count;
  duration_t              ticks_left;  // DDA ticks still to run in this move
  logic [buffer_size-1:0] taken;
  logic [buffer_size-1:0] pending;
  logic                   last_tick;

  assign pending    = stepready ^ taken;
  assign buffer_dtr = ~&pending;  // Room for at least one more move

  // Free-running tick divider
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_count <= '0;
      dda_tick   <= 1'b0;
    end else if (tick_count >= clock_divisor - 1'b1) begin
      tick_count <= '0;
      dda_tick   <= 1'b1;
    end else begin
      tick_count <= tick_count + 1'b1;
      dda_tick   <= 1'b0;
    end
  end

  // Zero-length moves finish without waiting for a tick
  assign last_tick = (ticks_left == '0) || (dda_tick && ticks_left == duration_t'(1));

  always_ff @(posedge CLK) begin
    if (resetn) begin
      moveind        <= '0;
      taken          <= '0;
      ticks_left     <= '0;
      loading_move   <= 1'b0;
      executing_move <= 1'b0;
      move_done      <= 1'b0;
    end else begin
      loading_move <= 1'b0;  // Both are single-cycle pulses
      move_done    <= 1'b0;
      if (loading_move) begin
        executing_move <= 1'b1;
        ticks_left     <= active_duration;
      end else if (executing_move) begin
        if (last_tick) begin
          executing_move <= 1'b0;
          move_done      <= 1'b1;
          taken[moveind] <= stepready[moveind];  // Slot free again
          moveind        <= moveind + 1'b1;
        end else if (dda_tick) begin
          ticks_left <= ticks_left - 1'b1;
        end
      end else if (pending[moveind]) begin
        loading_move <= 1'b1;
      end
    end
  end

endmodule

//--- design/axis_dda.sv
// Second-order DDA for one axis, giving the step level from the accumulator
`timescale 1ns/1ns

module axis_dda
  import motion_pkg::*;
(
  input  logic      CLK,
  input  logic      resetn,
  input  logic      dda_tick,
  input  logic      loading_move,
  input  logic      executing_move,
  input  dda_word_t increment,
  input  dda_word_t accel,
  output logic      step
);

  dda_word_t accumulator;
  dda_word_t rate;     // Running increment, grows by accel each tick
  dda_word_t accel_q;

  logic advance;

  assign advance = executing_move && dda_tick;

  // Position accumulator
  always_ff @(posedge CLK) begin
    if (resetn) begin
      accumulator <= '0;
    end else if (loading_move) begin
      accumulator <= '0;
    end else if (advance) begin
      accumulator <= accumulator + rate;  // Uses rate before this tick's update
    end
  end

  // Velocity and acceleration of the current move
  always_ff @(posedge CLK) begin
    if (loading_move) begin
      rate    <= increment;
      accel_q <= accel;
    end else if (advance) begin
      rate <= rate + accel_q;
    end
  end

  // Each rising edge of the top bit is one step
  assign step = accumulator[dda_bits-1];

endmodule

//--- design/stepper_motion_top.sv
// Stepper motion top level with host decoder, move sequencer and axis DDAs
`timescale 1ns/1ns

module stepper_motion_top
  import motion_pkg::*;
  import host_cmd_pkg::*;
#(
  parameter int num_motors = 2,
  parameter int buffer_size = 2,
  localparam int idx_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  host_word_t            word_data_received,
  input  logic                  word_received,
  output host_word_t            word_send_data,
  output logic                  buffer_dtr,
  output logic                  move_done,
  output logic [num_motors-1:0] step,
  output logic [num_motors-1:0] dir,
  output logic [num_motors-1:0] enable,
  output logic [num_motors-1:0] brake
);

  logic [idx_bits-1:0]        moveind;
  logic [buffer_size-1:0]     stepready;
  divisor_t                   clock_divisor;
  duration_t                  active_duration;
  dda_word_t [num_motors-1:0] active_increment;
  dda_word_t [num_motors-1:0] active_accel;
  logic                       dda_tick;
  logic                       loading_move;
  logic                       executing_move;

  host_command_decoder #(
    .num_motors (num_motors),
    .buffer_size(buffer_size)
  ) u_decoder (
    .CLK               (CLK),
    .resetn            (resetn),
    .word_data_received(word_data_received),
    .word_received     (word_received),
    .moveind           (moveind),
    .word_send_data    (word_send_data),
    .enable            (enable),
    .brake             (brake),
    .clock_divisor     (clock_divisor),
    .stepready         (stepready),
    .active_dir        (dir),  // Direction of the slot in execution
    .active_duration   (active_duration),
    .active_increment  (active_increment),
    .active_accel      (active_accel)
  );

  move_sequencer #(
    .buffer_size(buffer_size)
  ) u_sequencer (
    .CLK            (CLK),
    .resetn         (resetn),
    .clock_divisor  (clock_divisor),
    .stepready      (stepready),
    .active_duration(active_duration),
    .moveind        (moveind),
    .dda_tick       (dda_tick),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done),
    .buffer_dtr     (buffer_dtr)
  );

  // One step generator per motor, all paced by the same tick
  for (genvar g = 0; g < num_motors; g++) begin : g_axis
    axis_dda u_axis (
      .CLK           (CLK),
      .resetn        (resetn),
      .dda_tick      (dda_tick),
      .loading_move  (loading_move),
      .executing_move(executing_move),
      .increment     (active_increment[g]),
      .accel         (active_accel[g]),
      .step          (step[g])
    );
  end

endmodule

//--- verification/stepper_motion_assert.sv
// Concurrent checks on the move sequencer pulses and the DDA tick spacing
`timescale 1ns/1ns

module stepper_motion_assert (
  input logic CLK,
  input logic resetn,
  input logic dda_tick,
  input logic loading_move,
  input logic move_done
);

  // Move load lasts one cycle
  property load_single_cycle;
    @(posedge CLK) disable iff (resetn) loading_move |=> !loading_move;
  endproperty

  property done_single_cycle;
    @(posedge CLK) disable iff (resetn) move_done |=> !move_done;
  endproperty

  property load_done_exclusive;
    @(posedge CLK) disable iff (resetn) !(loading_move && move_done);
  endproperty

  // Divisor is at least two
  property tick_spacing;
    @(posedge CLK) disable iff (resetn) dda_tick |=> !dda_tick;
  endproperty

  a_load_pulse: assert property (load_single_cycle)
    else $error("loading_move stayed high for more than one cycle");
  a_done_pulse: assert property (done_single_cycle)
    else $error("move_done stayed high for more than one cycle");
  a_load_done: assert property (load_done_exclusive)
    else $error("loading_move and move_done were high together");
  a_tick_gap: assert property (tick_spacing)
    else $error("dda_tick was high on two consecutive cycles");

endmodule

bind move_sequencer stepper_motion_assert u_seq_assert (
  .CLK         (CLK),
  .resetn      (resetn),
  .dda_tick    (dda_tick),
  .loading_move(loading_move),
  .move_done   (move_done)
);

//--- verification/stepper_motion_tb.sv
// Testbench for the stepper motion controller with random moves and a DDA reference model
`timescale 1ns/1ns

module stepper_motion_tb
  import motion_pkg::*;
  import host_cmd_pkg::*;
();

  localparam int num_motors = 2;
  localparam int buffer_size = 2;
  localparam int half_period = 20;    // 40 ns clock
  localparam int reset_cycles = 10;
  localparam int drive_delay = 5;
  localparam logic [31:0] lcg_seed = 32'd4265;
  localparam int move_timeout = 4000;  // Cycles allowed for queued moves
  localparam int room_timeout = 4000;
  localparam int settle_cycles = 100;
  localparam int num_ctrl_words = 8;

  logic                  CLK;
  logic                  resetn;
  host_word_t            word_data_received;
  logic                  word_received;
  host_word_t            word_send_data;
  logic                  buffer_dtr;
  logic                  move_done;
  logic [num_motors-1:0] step;
  logic [num_motors-1:0] dir;
  logic [num_motors-1:0] enable;
  logic [num_motors-1:0] brake;

  logic [31:0] lcg_state;

  // Monitor state sampled on the falling edge
  int                    cycles = 0;
  int                    load_cycle = 0;
  int                    done_count = 0;
  int                    edge_count [num_motors];
  logic [num_motors-1:0] step_prev = '0;

  // Expected and observed results per move
  logic [num_motors-1:0] exp_dir_q [$];
  logic [num_motors-1:0] obs_dir_q [$];
  int                    exp_edges_q [$];
  int                    obs_edges_q [$];
  int                    exp_dur_q [$];
  int                    obs_latency_q [$];

  stepper_motion_top #(
    .num_motors (num_motors),
    .buffer_size(buffer_size)
  ) UUT (
    .CLK               (CLK),
    .resetn            (resetn),
    .word_data_received(word_data_received),
    .word_received     (word_received),
    .word_send_data    (word_send_data),
    .buffer_dtr        (buffer_dtr),
    .move_done         (move_done),
    .step              (step),
    .dir               (dir),
    .enable            (enable),
    .brake             (brake)
  );

  initial begin
    CLK = 1'b0;
    forever #half_period CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand_word();
    return {lcg_next(), lcg_next()};
  endfunction

  // Second-order DDA that counts rising edges of the accumulator top bit
  function automatic int model_step_edges(input dda_word_t inc, input dda_word_t acc,
                                          input int ticks);
    dda_word_t pos;
    dda_word_t rate;
    logic      prev_top;
    int        edges;
    pos = '0;
    rate = inc;
    prev_top = 1'b0;
    edges = 0;
    for (int t = 0; t < ticks; t++) begin
      pos = pos + rate;
      rate = rate + acc;  // Velocity changes after the position update
      if (pos[dda_bits-1] && !prev_top)
        edges++;
      prev_top = pos[dda_bits-1];
    end
    return edges;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      fail_run("Output value differs from the model");
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #drive_delay;
  endtask

  // Strobe high for two cycles and low for two
  task automatic send_word(input host_word_t data);
    word_data_received = data;
    word_received = 1'b1;
    repeat (2) next_cycle();
    word_received = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic wait_buffer_room();
    int waited;
    waited = 0;
    while (!buffer_dtr) begin
      if (waited == room_timeout)
        fail_run("Timed out waiting for buffer_dtr to rise");
      next_cycle();
      waited++;
    end
  endtask

  task automatic wait_moves_done(input int target);
    int waited;
    waited = 0;
    while (done_count < target) begin
      if (waited == move_timeout)
        fail_run("Timed out waiting for move_done");
      next_cycle();
      waited++;
    end
  endtask

  // Random move with its expected results queued before the words go out
  task automatic queue_random_move(input int min_ticks);
    logic [31:0]           r;
    logic [num_motors-1:0] dirs;
    duration_t             ticks;
    dda_word_t             inc [num_motors];
    dda_word_t             acc [num_motors];
    r = lcg_next();
    dirs = r[num_motors-1:0];
    ticks = duration_t'(min_ticks) + duration_t'(lcg_next() % 24);
    exp_dir_q.push_back(dirs);
    exp_dur_q.push_back(int'(ticks));
    for (int a = 0; a < num_motors; a++) begin
      inc[a] = rand_word() >> 3;                   // Positive and below 2^61
      acc[a] = dda_word_t'($signed(rand_word()) >>> 10);
      exp_edges_q.push_back(model_step_edges(inc[a], acc[a], int'(ticks)));
    end
    wait_buffer_room();
    send_word({cmd_coordinated_step, 56'(dirs)});
    send_word({32'h0, ticks});
    for (int a = 0; a < num_motors; a++) begin
      send_word(host_word_t'(inc[a]));
      send_word(host_word_t'(acc[a]));
    end
  endtask

  task automatic check_moves(input int divisor);
    int dur;
    int latency;
    while (exp_dur_q.size() > 0) begin
      if (obs_latency_q.size() == 0 || obs_dir_q.size() == 0)
        fail_run("A queued move was never loaded and finished");
      check_value("dir", 64'(obs_dir_q.pop_front()), 64'(exp_dir_q.pop_front()));
      for (int a = 0; a < num_motors; a++)
        check_value($sformatf("step[%0d] rising edges", a), 64'(obs_edges_q.pop_front()),
                    64'(exp_edges_q.pop_front()));
      dur = exp_dur_q.pop_front();
      latency = obs_latency_q.pop_front();
      if (latency < (dur - 1) * divisor || latency > (dur + 1) * divisor + 2)
        fail_run($sformatf("Move of %0d ticks took %0d cycles at divisor %0d",
                           dur, latency, divisor));
    end
  endtask

  // Step edges, move starts and move ends
  always @(negedge CLK) begin
    if (!resetn) begin
      cycles++;
      for (int a = 0; a < num_motors; a++)
        if (step[a] && !step_prev[a])
          edge_count[a]++;
      step_prev = step;
      if (UUT.loading_move) begin
        obs_dir_q.push_back(dir);
        load_cycle = cycles;
      end
      // Header direction holds for the whole move
      if (UUT.executing_move)
        check_value("dir", 64'(dir), 64'(exp_dir_q[obs_dir_q.size() - 1]));
      if (move_done) begin
        for (int a = 0; a < num_motors; a++) begin
          obs_edges_q.push_back(edge_count[a]);
          edge_count[a] = 0;
        end
        obs_latency_q.push_back(cycles - load_cycle);
        done_count++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    int          done_before;
    divisor_t    div;
    lcg_state = lcg_seed;
    resetn = 1'b1;
    word_received = 1'b0;
    word_data_received = '0;
    for (int a = 0; a < num_motors; a++)
      edge_count[a] = 0;
    repeat (reset_cycles) @(posedge CLK);
    #drive_delay;
    resetn = 1'b0;
    next_cycle();

    check_value("step", 64'(step), 64'(0));
    check_value("enable", 64'(enable), 64'(0));
    check_value("brake", 64'(brake), 64'(0));
    check_value("move_done", 64'(move_done), 64'(0));
    check_value("word_send_data", word_send_data, 64'(0));
    check_value("buffer_dtr", 64'(buffer_dtr), 64'(1));

    // Channel info bytes hold motors, 32-bit duration, 64-bit DDA and slots
    send_word({cmd_channel_info, 56'h0});
    check_value("word_send_data", word_send_data,
                {32'h0, 8'(buffer_size), 8'd64, 8'd32, 8'(num_motors)});
    send_word({8'h5c, 56'h0012_3456_789a});
    check_value("word_send_data", word_send_data, 64'(0));

    repeat (num_ctrl_words) begin
      r = lcg_next();
      r2 = lcg_next();
      send_word({cmd_motor_enable, r[23:0], r2});
      check_value("enable", 64'(enable), 64'(r2[num_motors-1:0]));
      r = lcg_next();
      r2 = lcg_next();
      send_word({cmd_motor_brake, r[23:0], r2});
      check_value("brake", 64'(brake), 64'(r2[num_motors-1:0]));
    end

    done_before = done_count;
    queue_random_move(4);
    wait_moves_done(done_before + 1);
    repeat (settle_cycles) next_cycle();
    check_value("move_done count", 64'(done_count), 64'(done_before + 1));
    check_moves(int'(default_clock_divisor));

    // Second move arrives while the first one runs
    done_before = done_count;
    queue_random_move(8);
    queue_random_move(8);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'(0));
    wait_moves_done(done_before + 2);
    repeat (settle_cycles) next_cycle();
    check_value("move_done count", 64'(done_count), 64'(done_before + 2));
    check_moves(int'(default_clock_divisor));

    r = lcg_next();
    div = divisor_t'(4 + r % 13);
    send_word({cmd_clk_divisor, 48'h0, div});
    check_value("clock_divisor", 64'(UUT.clock_divisor), 64'(div));
    repeat (3) begin
      done_before = done_count;
      queue_random_move(4);
      wait_moves_done(done_before + 1);
      check_moves(int'(div));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- build.f
design/motion_pkg.sv
design/host_cmd_pkg.sv
design/host_command_decoder.sv
design/move_sequencer.sv
design/axis_dda.sv
design/stepper_motion_top.sv
verification/stepper_motion_assert.sv
verification/stepper_motion_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the stepper motion testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module stepper_motion_tb -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vstepper_motion_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
